/* logic/fp_ci_pkg.sv */
// Floating-point conversion unit shared types, function codes and format constants
package fp_ci_pkg;

    // IEEE-754 binary32
    typedef struct packed {
        logic       sign;
        logic [7:0] exp;
        logic [22:0] frac;
    } fp32_t;

    // IEEE-754 binary16
    typedef struct packed {
        logic       sign;
        logic [4:0] exp;
        logic [9:0] frac;
    } fp16_t;

    // Custom-instruction function select
    typedef enum logic {
        func_f32_to_f16 = 1'b0,
        func_f16_to_f32 = 1'b1
    } ci_func_e;

    // Exponent biases
    localparam int fp32_bias = 127;
    localparam int fp16_bias = 15;

    // All-ones exponent, used by Inf and NaN
    localparam int fp32_exp_max = 255;
    localparam int fp16_exp_max = 31;

    // Quiet bit position in each fraction
    localparam int fp16_qnan_bit = 9;
    localparam int fp32_qnan_bit = 22;

endpackage

/* logic/float32to16.sv */
// Single-to-half narrowing converter with round to nearest, ties to even
`timescale 1ns/1ns

module float32to16 (
    input  logic              slave_clk,
    input  logic              slave_reset,
    input  logic              slave_clk_en,
    input  logic              start,
    input  fp_ci_pkg::fp32_t  operand,
    output logic              done,
    output fp_ci_pkg::fp16_t  result
);

    // Exponent difference between the two formats
    localparam int rebias = fp_ci_pkg::fp32_bias - fp_ci_pkg::fp16_bias;
    // At or above this the half overflows to infinity
    localparam int exp_ovf = rebias + fp_ci_pkg::fp16_exp_max;
    // Below 2^-25 everything flushes to zero
    localparam int exp_min = fp_ci_pkg::fp32_bias - 25;
    // Subnormal offset is sub_base minus the single exponent
    localparam int sub_base = rebias + 13;
    // Guard position for normal results, just under the kept 10 bits
    localparam int norm_offset = 12;
    localparam logic [9:0] qnan16 = 10'(1) << fp_ci_pkg::fp16_qnan_bit;

    logic        is_nan_inf;
    logic        is_ovf;
    logic        is_unf;
    logic        is_sub;
    logic        needs_round;

    logic [1:0]  stage;
    logic [4:0]  round_offset;
    logic [23:0] round_target;
    logic [9:0]  round_shifted;
    logic [23:0] guard_mask;
    logic [23:0] keep_mask;
    logic        round_up;

    always_comb begin
        is_nan_inf  = operand.exp == 8'(fp_ci_pkg::fp32_exp_max);
        is_ovf      = operand.exp >= 8'(exp_ovf);
        is_unf      = operand.exp < 8'(exp_min);
        is_sub      = operand.exp <= 8'(rebias);
        needs_round = !(is_nan_inf || is_ovf || is_unf);
    end

    // Guard set, and either the kept LSB or a sticky bit set
    assign round_up = (|(round_target & guard_mask)) && (|(round_target & keep_mask));

    always_ff @(posedge slave_clk) begin
        if (slave_reset) begin
            stage <= '0;
            done  <= 1'b0;
        end else if (slave_clk_en) begin
            stage[0] <= start && needs_round;
            stage[1] <= stage[0];
            done     <= (start && !needs_round) || stage[1];
        end
    end

    always_ff @(posedge slave_clk) begin
        if (slave_clk_en) begin
            if (start) begin
                result.sign <= operand.sign;
                if (is_nan_inf) begin
                    result.exp  <= 5'(fp_ci_pkg::fp16_exp_max);
                    result.frac <= operand.frac[22:13] | ((operand.frac != '0) ? qnan16 : '0);
                end else if (is_ovf) begin
                    result.exp  <= 5'(fp_ci_pkg::fp16_exp_max);
                    result.frac <= '0;
                end else if (is_unf) begin
                    result.exp  <= '0;
                    result.frac <= '0;
                end else if (is_sub) begin
                    // Hidden bit joins the target, exponent stays zero
                    result.exp   <= '0;
                    round_offset <= 5'(8'(sub_base) - operand.exp);
                    round_target <= {1'b1, operand.frac};
                end else begin
                    result.exp   <= 5'(operand.exp - 8'(rebias));
                    round_offset <= 5'(norm_offset);
                    round_target <= {1'b0, operand.frac};
                end
            end

            // Shift and masks
            if (stage[0]) begin
                round_shifted <= 10'(round_target >> (round_offset + 5'd1));
                guard_mask    <= 24'd1 << round_offset;
                keep_mask     <= (24'd1 << (round_offset + 5'd1))
                               | ((24'd1 << round_offset) - 24'd1);
            end

            // All-ones mantissa carries into the exponent
            if (stage[1]) begin
                if (round_up) begin
                    result.exp  <= result.exp + 5'(&round_shifted);
                    result.frac <= round_shifted + 10'd1;
                end else begin
                    result.frac <= round_shifted;
                end
            end
        end
    end

    // Done follows its start by the special-case or the rounding latency
    assert property (@(posedge slave_clk iff slave_clk_en) disable iff (slave_reset)
        done |-> ($past(start, 1) || $past(start, 3)));

endmodule

/* logic/float16to32.sv */
// Half-to-single widening converter, exact, with subnormal normalization
`timescale 1ns/1ns

module float16to32 (
    input  logic              slave_clk,
    input  logic              slave_reset,
    input  logic              slave_clk_en,
    input  logic              start,
    input  fp_ci_pkg::fp16_t  operand,
    output logic              done,
    output fp_ci_pkg::fp32_t  result
);

    localparam int rebias = fp_ci_pkg::fp32_bias - fp_ci_pkg::fp16_bias;
    // Subnormal exponent drops from here by the normalizing shift
    localparam int sub_exp_base = rebias + 1;
    localparam logic [22:0] qnan32 = 23'(1) << fp_ci_pkg::fp32_qnan_bit;

    logic [3:0] sub_shift;
    logic [9:0] sub_frac;

    // Shift that brings the leading one out of the fraction
    function automatic logic [3:0] frac_shift(input logic [9:0] f);
        logic [3:0] n;
        n = 4'd10;
        for (int i = 0; i <= 9; i++) begin
            if (f[i]) begin
                n = 4'(10 - i);
            end
        end
        return n;
    endfunction

    always_comb begin
        sub_shift = frac_shift(operand.frac);
        sub_frac  = operand.frac << sub_shift;
    end

    always_ff @(posedge slave_clk) begin
        if (slave_reset) begin
            done <= 1'b0;
        end else if (slave_clk_en) begin
            done <= start;
        end
    end

    always_ff @(posedge slave_clk) begin
        if (slave_clk_en && start) begin
            result.sign <= operand.sign;
            if (operand.exp == 5'(fp_ci_pkg::fp16_exp_max)) begin
                // Inf or NaN, payload kept on top
                result.exp  <= 8'(fp_ci_pkg::fp32_exp_max);
                result.frac <= {operand.frac, 13'd0} | ((operand.frac != '0) ? qnan32 : '0);
            end else if (operand.exp != '0) begin
                result.exp  <= {3'd0, operand.exp} + 8'(rebias);
                result.frac <= {operand.frac, 13'd0};
            end else if (operand.frac == '0) begin
                // Signed zero
                result.exp  <= '0;
                result.frac <= '0;
            end else begin
                result.exp  <= 8'(sub_exp_base) - {4'd0, sub_shift};
                result.frac <= {sub_frac, 13'd0};
            end
        end
    end

    // Fixed single-edge latency
    assert property (@(posedge slave_clk iff slave_clk_en) disable iff (slave_reset)
        done == $past(start));

endmodule

/* logic/ci_dispatch.sv */
// Custom-instruction dispatcher, routes start and returns the active converter's result
`timescale 1ns/1ns

module ci_dispatch (
    input  logic                  slave_clk,
    input  logic                  slave_reset,
    input  logic                  slave_clk_en,
    input  logic                  slave_start,
    input  fp_ci_pkg::ci_func_e   slave_n,
    output logic                  start_narrow,
    output logic                  start_widen,
    input  logic                  narrow_done,
    input  fp_ci_pkg::fp16_t      narrow_result,
    input  logic                  widen_done,
    input  fp_ci_pkg::fp32_t      widen_result,
    output logic                  slave_done,
    output logic [31:0]           slave_result
);

    logic                 busy_q;
    fp_ci_pkg::ci_func_e  func_q;

    assign start_narrow = slave_start && (slave_n == fp_ci_pkg::func_f32_to_f16);
    assign start_widen  = slave_start && (slave_n == fp_ci_pkg::func_f16_to_f32);

    // Function in flight
    always_ff @(posedge slave_clk) begin
        if (slave_reset) begin
            busy_q <= 1'b0;
            func_q <= fp_ci_pkg::func_f32_to_f16;
        end else if (slave_clk_en) begin
            if (slave_start) begin
                busy_q <= 1'b1;
                func_q <= slave_n;
            end else if (slave_done) begin
                busy_q <= 1'b0;
            end
        end
    end

    // No register here, done and result pass straight through
    always_comb begin
        if (func_q == fp_ci_pkg::func_f32_to_f16) begin
            slave_done   = narrow_done;
            slave_result = {16'h0000, narrow_result};
        end else begin
            slave_done   = widen_done;
            slave_result = widen_result;
        end
    end

    assert property (@(posedge slave_clk iff slave_clk_en) disable iff (slave_reset)
        slave_start |-> !busy_q);

    // A converter finishes only an instruction this block started
    assert property (@(posedge slave_clk iff slave_clk_en) disable iff (slave_reset)
        (narrow_done || widen_done) |-> busy_q);

    assert property (@(posedge slave_clk iff slave_clk_en) disable iff (slave_reset)
        !(narrow_done && widen_done));

endmodule

/* logic/fp_convert_ci.sv */
// Float conversion custom instruction, single/half narrowing and widening
`timescale 1ns/1ns

module fp_convert_ci (
    input  logic                 slave_clk,
    input  logic                 slave_reset,
    input  logic                 slave_clk_en,
    input  logic                 slave_start,
    input  fp_ci_pkg::ci_func_e  slave_n,
    input  logic [31:0]          slave_dataa,
    output logic                 slave_done,
    output logic [31:0]          slave_result
);

    logic              start_narrow;
    logic              start_widen;
    logic              narrow_done;
    logic              widen_done;
    fp_ci_pkg::fp16_t  narrow_result;
    fp_ci_pkg::fp32_t  widen_result;

    ci_dispatch u_dispatch (
        .slave_clk     (slave_clk),
        .slave_reset   (slave_reset),
        .slave_clk_en  (slave_clk_en),
        .slave_start   (slave_start),
        .slave_n       (slave_n),
        .start_narrow  (start_narrow),
        .start_widen   (start_widen),
        .narrow_done   (narrow_done),
        .narrow_result (narrow_result),
        .widen_done    (widen_done),
        .widen_result  (widen_result),
        .slave_done    (slave_done),
        .slave_result  (slave_result)
    );

    float32to16 u_narrow (
        .slave_clk    (slave_clk),
        .slave_reset  (slave_reset),
        .slave_clk_en (slave_clk_en),
        .start        (start_narrow),
        .operand      (fp_ci_pkg::fp32_t'(slave_dataa)),
        .done         (narrow_done),
        .result       (narrow_result)
    );

    // Half operand sits in the low 16 bits
    float16to32 u_widen (
        .slave_clk    (slave_clk),
        .slave_reset  (slave_reset),
        .slave_clk_en (slave_clk_en),
        .start        (start_widen),
        .operand      (fp_ci_pkg::fp16_t'(slave_dataa[15:0])),
        .done         (widen_done),
        .result       (widen_result)
    );

endmodule

/* dv/fp_ci_clock_gen.sv */
// Testbench clock and synchronous reset source for the conversion unit
`timescale 1ns/1ns

module fp_ci_clock_gen (
    output logic slave_clk,
    output logic slave_reset
);

    // 4 ns period
    initial begin
        slave_clk = 1'b0;
        forever begin
            #2 slave_clk = ~slave_clk;
        end
    end

    // Reset held over the first two rising edges
    initial begin
        slave_reset = 1'b1;
        repeat (2) @(posedge slave_clk);
        #1 slave_reset = 1'b0;
    end

endmodule

/* dv/fp_ci_vectors.svh */
// Conversion vectors, one row per instruction with function code, operand and expected result
`ifndef fp_ci_vectors_svh
`define fp_ci_vectors_svh

localparam int num_vectors = 27;

localparam vector_t vector_table [num_vectors] = '{
    // Narrowing normals, round down, round up, ties both ways, overflow by rounding
    '{fp_ci_pkg::func_f32_to_f16, 32'h3F800000, 32'h00003C00},
    '{fp_ci_pkg::func_f32_to_f16, 32'h477FE000, 32'h00007BFF},
    '{fp_ci_pkg::func_f32_to_f16, 32'h3F800800, 32'h00003C00},
    '{fp_ci_pkg::func_f32_to_f16, 32'h3F801800, 32'h00003C01},
    '{fp_ci_pkg::func_f32_to_f16, 32'h3F801000, 32'h00003C00},
    '{fp_ci_pkg::func_f32_to_f16, 32'h3F803000, 32'h00003C02},
    '{fp_ci_pkg::func_f32_to_f16, 32'h477FF000, 32'h00007C00},
    // Narrowing into subnormals and flush to signed zero
    '{fp_ci_pkg::func_f32_to_f16, 32'h387FFFFF, 32'h00000400},
    '{fp_ci_pkg::func_f32_to_f16, 32'h38006000, 32'h00000202},
    '{fp_ci_pkg::func_f32_to_f16, 32'h33800000, 32'h00000001},
    '{fp_ci_pkg::func_f32_to_f16, 32'h33C00000, 32'h00000002},
    '{fp_ci_pkg::func_f32_to_f16, 32'h33000000, 32'h00000000},
    '{fp_ci_pkg::func_f32_to_f16, 32'hB2800000, 32'h00008000},
    // Narrowing specials
    '{fp_ci_pkg::func_f32_to_f16, 32'h7F800000, 32'h00007C00},
    '{fp_ci_pkg::func_f32_to_f16, 32'hFF800000, 32'h0000FC00},
    '{fp_ci_pkg::func_f32_to_f16, 32'h7F800001, 32'h00007E00},
    '{fp_ci_pkg::func_f32_to_f16, 32'hFF800001, 32'h0000FE00},
    '{fp_ci_pkg::func_f32_to_f16, 32'h47800000, 32'h00007C00},
    // Widening, upper operand bits are ignored
    '{fp_ci_pkg::func_f16_to_f32, 32'hABCD3C00, 32'h3F800000},
    '{fp_ci_pkg::func_f16_to_f32, 32'h00007BFF, 32'h477FE000},
    '{fp_ci_pkg::func_f16_to_f32, 32'h00000000, 32'h00000000},
    '{fp_ci_pkg::func_f16_to_f32, 32'h00008000, 32'h80000000},
    '{fp_ci_pkg::func_f16_to_f32, 32'h00000001, 32'h33800000},
    '{fp_ci_pkg::func_f16_to_f32, 32'h00008003, 32'hB4400000},
    '{fp_ci_pkg::func_f16_to_f32, 32'h00007C00, 32'h7F800000},
    '{fp_ci_pkg::func_f16_to_f32, 32'h0000FC00, 32'hFF800000},
    '{fp_ci_pkg::func_f16_to_f32, 32'h00007C01, 32'h7FC02000}
};

`endif

/* dv/fp_convert_ci_tb.sv */
// Table-driven testbench for the float conversion custom instruction with clock-enable stalls
`timescale 1ns/1ns

module fp_convert_ci_tb;

    typedef struct packed {
        fp_ci_pkg::ci_func_e func;
        logic [31:0]         operand;
        logic [31:0]         expected;
    } vector_t;

    `include "fp_ci_vectors.svh"

    // Longest latency per row, stretched by stalls, plus reset and drain
    localparam int cycle_limit = num_vectors * 3 * 4 + 50;

    logic                 slave_clk;
    logic                 slave_reset;
    logic                 slave_clk_en;
    logic                 slave_start;
    fp_ci_pkg::ci_func_e  slave_n;
    logic [31:0]          slave_dataa;
    logic                 slave_done;
    logic [31:0]          slave_result;

    logic stalls_on;
    logic in_flight;
    int   value_errors;
    int   protocol_errors;
    int   done_count;
    int   cycle_count = 0;

    fp_ci_clock_gen u_clock_gen (
        .slave_clk   (slave_clk),
        .slave_reset (slave_reset)
    );

    fp_convert_ci dut (
        .slave_clk    (slave_clk),
        .slave_reset  (slave_reset),
        .slave_clk_en (slave_clk_en),
        .slave_start  (slave_start),
        .slave_n      (slave_n),
        .slave_dataa  (slave_dataa),
        .slave_done   (slave_done),
        .slave_result (slave_result)
    );

    task automatic check_half(input int row, input fp_ci_pkg::fp16_t expected,
                              input logic [31:0] actual);
        // Upper half of the result must be zero
        if (actual !== {16'h0000, expected}) begin
            value_errors++;
            $display("mismatch slave_result row %0d expected 0x%08h actual 0x%08h",
                     row, {16'h0000, expected}, actual);
        end
    endtask

    task automatic check_single(input int row, input fp_ci_pkg::fp32_t expected,
                                input fp_ci_pkg::fp32_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("mismatch slave_result row %0d expected 0x%08h actual 0x%08h",
                     row, expected, actual);
        end
    endtask

    // Advance one edge and track done and start as the processor takes them
    task automatic advance_edge(output logic enabled);
        logic done_before;
        done_before = slave_done;
        @(posedge slave_clk);
        enabled = slave_clk_en;
        if (enabled && done_before) begin
            done_count++;
            if (!in_flight) begin
                protocol_errors++;
                $display("slave_done arrived with no instruction in flight");
            end
            in_flight = 1'b0;
        end
        if (enabled && slave_start) begin
            in_flight = 1'b1;
        end
        #1;
        slave_clk_en = stalls_on ? (($urandom % 4) != 0) : 1'b1;
    endtask

    always @(posedge slave_clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout, run did not finish within %0d cycles", cycle_limit);
            $display("errors value %0d protocol %0d", value_errors, protocol_errors);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        logic    enabled;
        vector_t row;
        slave_clk_en    = 1'b1;
        slave_start     = 1'b0;
        slave_n         = fp_ci_pkg::func_f32_to_f16;
        slave_dataa     = '0;
        stalls_on       = 1'b0;
        in_flight       = 1'b0;
        value_errors    = 0;
        protocol_errors = 0;
        done_count      = 0;
        void'($urandom(32'h5297));

        // Done stays low while idle after reset
        @(negedge slave_reset);
        repeat (4) begin
            advance_edge(enabled);
            if (slave_done !== 1'b0) begin
                value_errors++;
                $display("mismatch slave_done expected 0x0 actual 0x%0h", slave_done);
            end
        end

        stalls_on = 1'b1;
        for (int i = 0; i < num_vectors; i++) begin
            row         = vector_table[i];
            slave_n     = row.func;
            slave_dataa = row.operand;
            slave_start = 1'b1;
            enabled     = 1'b0;
            while (!enabled) begin
                advance_edge(enabled);
            end
            slave_start = 1'b0;
            while (slave_done !== 1'b1) begin
                advance_edge(enabled);
            end
            if (row.func == fp_ci_pkg::func_f32_to_f16) begin
                check_half(i, fp_ci_pkg::fp16_t'(row.expected[15:0]), slave_result);
            end else begin
                check_single(i, fp_ci_pkg::fp32_t'(row.expected),
                             fp_ci_pkg::fp32_t'(slave_result));
            end
            // The processor takes done on the next enabled edge
            enabled = 1'b0;
            while (!enabled) begin
                advance_edge(enabled);
            end
        end

        // Trailing edges catch any extra done
        stalls_on = 1'b0;
        repeat (3) begin
            advance_edge(enabled);
        end
        if (done_count != num_vectors) begin
            protocol_errors++;
            $display("expected %0d done pulses but counted %0d", num_vectors, done_count);
        end

        $display("errors value %0d protocol %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+dv
logic/fp_ci_pkg.sv
logic/float32to16.sv
logic/float16to32.sv
logic/ci_dispatch.sv
logic/fp_convert_ci.sv
dv/fp_ci_clock_gen.sv
dv/fp_convert_ci_tb.sv
